// ==== hw/mipsDefs.svh ====
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

////////////////////////////////////////////////////////////////////
// datapath sizing

`define MIPS_WIDTH   32          // data and address bits
`define MIPS_REGBITS 5           // register address bits
`define MIPS_NUMREGS 32          // size of the register file

////////////////////////////////////////////////////////////////////
// reset values

// first instruction fetched from here
`define MIPS_RESETPC 32'h0000_0000

`endif

// ==== hw/mipsPkg.sv ====
package mipsPkg;

   ////////////////////////////////////////////////////////////////////
   // control states

   typedef enum logic [4:0] {
      Fetch, Decode, MemAdr, LwRead, LwWrite, SbWrite, ShWrite,
      RtypeEx, RtypeWr, BeqEx, BneEx, JumpEx,
      AddiEx, AndiEx, OriEx, LuiEx, ImmWr
   } stateT;

   ////////////////////////////////////////////////////////////////////
   // instruction fields

   typedef enum logic [5:0] {
      opRtype = 6'b000000,
      opJ     = 6'b000010,
      opBeq   = 6'b000100,
      opBne   = 6'b000101,
      opAddi  = 6'b001000,
      opAndi  = 6'b001100,
      opOri   = 6'b001101,
      opLui   = 6'b001111,
      opLw    = 6'b100011,
      opSb    = 6'b101000,
      opSh    = 6'b101001
   } opcodeT;

   typedef enum logic [5:0] {
      fnSll = 6'b000000,
      fnSrl = 6'b000010,
      fnAdd = 6'b100000,
      fnSub = 6'b100010,
      fnOr  = 6'b100101
   } functT;

   ////////////////////////////////////////////////////////////////////
   // datapath controls

   typedef enum logic [2:0] {
      aluAdd, aluSub, aluAnd, aluOr, aluSll, aluSrl, aluLui
   } aluFuncT;

   typedef enum logic {srcAPc, srcARegA} srcASelT;

   typedef enum logic [1:0] {
      srcBRegB, srcBFour, srcBSignImm, srcBBranchOffset
   } srcBSelT;

   typedef enum logic [1:0] {pcAluResult, pcAluOut, pcJumpTarget} pcSrcT;

   typedef enum logic {dstRt, dstRd} regDstT;

   // width of a store on the bus
   typedef enum logic [1:0] {sizeNone, sizeHalf, sizeByte} storeSizeT;

endpackage

// ==== hw/mipsDecode.sv ====
`timescale 1ns/10ps

module mipsDecode
(
   input  logic               clk,
   input  logic               reset,
   input  mipsPkg::opcodeT    op,
   input  mipsPkg::functT     funct,
   output logic               irWrite,
   output logic               pcWrite,
   output logic               branchEq,
   output logic               branchNe,
   output mipsPkg::pcSrcT     pcSrc,
   output logic               iOrD,
   output logic               memRead,
   output logic               memWrite,
   output mipsPkg::storeSizeT storeSize,
   output mipsPkg::srcASelT   srcASel,
   output mipsPkg::srcBSelT   srcBSel,
   output mipsPkg::aluFuncT   aluFunc,
   output logic               regWrite,
   output mipsPkg::regDstT    regDst,
   output logic               memToReg
);

   mipsPkg::stateT  state, nextState;
   mipsPkg::aluFuncT rtypeFunc;    // alu op picked by funct

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= mipsPkg::Fetch;
      else
         state <= nextState;
   end

   ////////////////////////////////////////////////////////////////////
   // next state

   always_comb
   begin
      nextState = mipsPkg::Fetch;
      case (state)
         mipsPkg::Fetch:   nextState = mipsPkg::Decode;
         mipsPkg::Decode:
            case (op)
               mipsPkg::opLw, mipsPkg::opSb, mipsPkg::opSh:
                                nextState = mipsPkg::MemAdr;
               mipsPkg::opRtype: nextState = mipsPkg::RtypeEx;
               mipsPkg::opBeq:   nextState = mipsPkg::BeqEx;
               mipsPkg::opBne:   nextState = mipsPkg::BneEx;
               mipsPkg::opJ:     nextState = mipsPkg::JumpEx;
               mipsPkg::opAddi:  nextState = mipsPkg::AddiEx;
               mipsPkg::opAndi:  nextState = mipsPkg::AndiEx;
               mipsPkg::opOri:   nextState = mipsPkg::OriEx;
               mipsPkg::opLui:   nextState = mipsPkg::LuiEx;
               default:          nextState = mipsPkg::Fetch;    // unknown op
            endcase
         mipsPkg::MemAdr:
            case (op)
               mipsPkg::opLw: nextState = mipsPkg::LwRead;
               mipsPkg::opSb: nextState = mipsPkg::SbWrite;
               mipsPkg::opSh: nextState = mipsPkg::ShWrite;
               default:       nextState = mipsPkg::Fetch;
            endcase
         mipsPkg::LwRead:  nextState = mipsPkg::LwWrite;
         mipsPkg::RtypeEx: nextState = mipsPkg::RtypeWr;
         mipsPkg::AddiEx, mipsPkg::AndiEx, mipsPkg::OriEx, mipsPkg::LuiEx:
                           nextState = mipsPkg::ImmWr;
         default:          nextState = mipsPkg::Fetch;  // all last states
      endcase
   end

   // R-type function field to alu op
   always_comb
   begin
      case (funct)
         mipsPkg::fnSub: rtypeFunc = mipsPkg::aluSub;
         mipsPkg::fnOr:  rtypeFunc = mipsPkg::aluOr;
         mipsPkg::fnSll: rtypeFunc = mipsPkg::aluSll;
         mipsPkg::fnSrl: rtypeFunc = mipsPkg::aluSrl;
         default:        rtypeFunc = mipsPkg::aluAdd;
      endcase
   end

   ////////////////////////////////////////////////////////////////////
   // per-state controls

   always_comb
   begin
      irWrite = 1'b0;
      pcWrite = 1'b0;
      branchEq = 1'b0;
      branchNe = 1'b0;
      pcSrc = mipsPkg::pcAluResult;
      iOrD = 1'b0;
      memRead = 1'b0;
      memWrite = 1'b0;
      storeSize = mipsPkg::sizeNone;
      srcASel = mipsPkg::srcARegA;
      srcBSel = mipsPkg::srcBRegB;
      aluFunc = mipsPkg::aluAdd;
      regWrite = 1'b0;
      regDst = mipsPkg::dstRt;
      memToReg = 1'b0;
      case (state)
         mipsPkg::Fetch:
         begin
            memRead = 1'b1;
            irWrite = 1'b1;
            pcWrite = 1'b1;              // pc + 4
            srcASel = mipsPkg::srcAPc;
            srcBSel = mipsPkg::srcBFour;
         end
         mipsPkg::Decode:
         begin
            // branch target lands in aluOut
            srcASel = mipsPkg::srcAPc;
            srcBSel = mipsPkg::srcBBranchOffset;
         end
         mipsPkg::MemAdr:  srcBSel = mipsPkg::srcBSignImm;
         mipsPkg::LwRead:
         begin
            memRead = 1'b1;
            iOrD = 1'b1;
         end
         mipsPkg::LwWrite:
         begin
            regWrite = 1'b1;
            memToReg = 1'b1;
         end
         mipsPkg::SbWrite, mipsPkg::ShWrite:
         begin
            memWrite = 1'b1;
            iOrD = 1'b1;
            storeSize = (state == mipsPkg::SbWrite) ? mipsPkg::sizeByte : mipsPkg::sizeHalf;
         end
         mipsPkg::RtypeEx: aluFunc = rtypeFunc;
         mipsPkg::RtypeWr:
         begin
            regWrite = 1'b1;
            regDst = mipsPkg::dstRd;
         end
         mipsPkg::BeqEx, mipsPkg::BneEx:
         begin
            aluFunc = mipsPkg::aluSub;   // zero when equal
            pcSrc = mipsPkg::pcAluOut;
            branchEq = (state == mipsPkg::BeqEx);
            branchNe = (state == mipsPkg::BneEx);
         end
         mipsPkg::JumpEx:
         begin
            pcWrite = 1'b1;
            pcSrc = mipsPkg::pcJumpTarget;
         end
         mipsPkg::AddiEx:  srcBSel = mipsPkg::srcBSignImm;
         mipsPkg::AndiEx:
         begin
            srcBSel = mipsPkg::srcBSignImm;
            aluFunc = mipsPkg::aluAnd;
         end
         mipsPkg::OriEx:
         begin
            srcBSel = mipsPkg::srcBSignImm;
            aluFunc = mipsPkg::aluOr;
         end
         mipsPkg::LuiEx:
         begin
            srcBSel = mipsPkg::srcBSignImm;
            aluFunc = mipsPkg::aluLui;
         end
         mipsPkg::ImmWr:   regWrite = 1'b1;
         default:          ;
      endcase
   end

   // single shared bus, one direction per cycle
   assert property (@(posedge clk) disable iff (reset) !(memRead && memWrite))
      else $error("memRead and memWrite high together");
   assert property (@(posedge clk) disable iff (reset)
                    (storeSize != mipsPkg::sizeNone) |-> memWrite)
      else $error("storeSize set without memWrite");

endmodule

// ==== hw/mipsFetch.sv ====
`timescale 1ns/10ps
`include "mipsDefs.svh"

module mipsFetch
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic [`MIPS_WIDTH-1:0] readData,
   input  logic                   irWrite,
   input  logic                   pcWrite,
   input  logic                   branchEq,
   input  logic                   branchNe,
   input  mipsPkg::pcSrcT         pcSrc,
   input  logic [`MIPS_WIDTH-1:0] aluResult,
   input  logic [`MIPS_WIDTH-1:0] aluOut,
   input  logic                   zero,
   output logic [`MIPS_WIDTH-1:0] pc,
   output logic [`MIPS_WIDTH-1:0] instr
);

   logic [`MIPS_WIDTH-1:0] nextPc;
   logic [`MIPS_WIDTH-1:0] jumpTarget;
   logic                   pcEn;

   // region bits of pc + 4 with the word index
   assign jumpTarget = {pc[`MIPS_WIDTH-1:28], instr[25:0], 2'b00};

   always_comb
   begin
      case (pcSrc)
         mipsPkg::pcAluOut:     nextPc = aluOut;
         mipsPkg::pcJumpTarget: nextPc = jumpTarget;
         default:               nextPc = aluResult;
      endcase
   end

   assign pcEn = pcWrite | (branchEq & zero) | (branchNe & ~zero);

   always_ff @(posedge clk)
   begin
      if (reset)
         pc <= `MIPS_RESETPC;
      else if (pcEn)
         pc <= nextPc;
   end

   always_ff @(posedge clk)
   begin
      if (irWrite)
         instr <= readData;   // held until next fetch
   end

   // word-aligned fetches only
   assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
      else $error("pc not word aligned: %h", pc);

endmodule

// ==== hw/mipsExecute.sv ====
`timescale 1ns/10ps
`include "mipsDefs.svh"

module mipsExecute
(
   input  logic                   clk,
   input  logic [`MIPS_WIDTH-1:0] pc,
   input  logic [`MIPS_WIDTH-1:0] instr,
   input  logic [`MIPS_WIDTH-1:0] rd1,
   input  logic [`MIPS_WIDTH-1:0] rd2,
   input  mipsPkg::srcASelT       srcASel,
   input  mipsPkg::srcBSelT       srcBSel,
   input  mipsPkg::aluFuncT       aluFunc,
   output logic [`MIPS_WIDTH-1:0] aluResult,
   output logic [`MIPS_WIDTH-1:0] aluOut,
   output logic                   zero,
   output logic [`MIPS_WIDTH-1:0] writeData
);

   logic [`MIPS_WIDTH-1:0] regA, regB;
   logic [`MIPS_WIDTH-1:0] immExt, branchOffset, shiftAmt;
   logic [`MIPS_WIDTH-1:0] srcA, srcB;
   logic                   isShift, isLogic;

   // register file reads, captured every cycle
   always_ff @(posedge clk)
   begin
      regA <= rd1;
      regB <= rd2;
      aluOut <= aluResult;
   end

   assign writeData = regB;

   ////////////////////////////////////////////////////////////////////
   // operands

   assign isShift = (aluFunc == mipsPkg::aluSll) || (aluFunc == mipsPkg::aluSrl);
   assign isLogic = (aluFunc == mipsPkg::aluAnd) || (aluFunc == mipsPkg::aluOr);

   // andi and ori take the immediate unsigned
   assign immExt = isLogic ? {{(`MIPS_WIDTH-16){1'b0}}, instr[15:0]}
                           : {{(`MIPS_WIDTH-16){instr[15]}}, instr[15:0]};
   assign branchOffset = {{(`MIPS_WIDTH-18){instr[15]}}, instr[15:0], 2'b00};
   assign shiftAmt = {{(`MIPS_WIDTH-5){1'b0}}, instr[10:6]};   // shamt field

   always_comb
   begin
      if (srcASel == mipsPkg::srcAPc)
         srcA = pc;
      else
         srcA = isShift ? shiftAmt : regA;
   end

   always_comb
   begin
      case (srcBSel)
         mipsPkg::srcBFour:         srcB = `MIPS_WIDTH'(4);
         mipsPkg::srcBSignImm:      srcB = immExt;
         mipsPkg::srcBBranchOffset: srcB = branchOffset;
         default:                   srcB = regB;
      endcase
   end

   ////////////////////////////////////////////////////////////////////
   // alu

   always_comb
   begin
      case (aluFunc)
         mipsPkg::aluSub: aluResult = srcA - srcB;
         mipsPkg::aluAnd: aluResult = srcA & srcB;
         mipsPkg::aluOr:  aluResult = srcA | srcB;
         mipsPkg::aluSll: aluResult = srcB << srcA[4:0];
         mipsPkg::aluSrl: aluResult = srcB >> srcA[4:0];
         mipsPkg::aluLui: aluResult = srcB << 16;     // immediate to top half
         default:         aluResult = srcA + srcB;
      endcase
   end

   assign zero = (aluResult == '0);

endmodule

// ==== hw/mipsResult.sv ====
`timescale 1ns/10ps
`include "mipsDefs.svh"

module mipsResult
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic [`MIPS_WIDTH-1:0] instr,
   input  logic [`MIPS_WIDTH-1:0] readData,
   input  logic [`MIPS_WIDTH-1:0] aluOut,
   input  logic                   regWrite,
   input  mipsPkg::regDstT        regDst,
   input  logic                   memToReg,
   output logic [`MIPS_WIDTH-1:0] rd1,
   output logic [`MIPS_WIDTH-1:0] rd2
);

   logic [`MIPS_WIDTH-1:0]  regs [`MIPS_NUMREGS];
   logic [`MIPS_WIDTH-1:0]  memData;
   logic [`MIPS_WIDTH-1:0]  writeValue;
   logic [`MIPS_REGBITS-1:0] rs, rt, rd, writeAdr;

   assign rs = instr[25:21];
   assign rt = instr[20:16];
   assign rd = instr[15:11];

   always_ff @(posedge clk)
   begin
      memData <= readData;   // load data, one cycle later
   end

   ////////////////////////////////////////////////////////////////////
   // write-back

   assign writeAdr = (regDst == mipsPkg::dstRd) ? rd : rt;
   assign writeValue = memToReg ? memData : aluOut;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < `MIPS_NUMREGS; i++)
            regs[i] <= '0;
      end
      else if (regWrite)
         regs[writeAdr] <= writeValue;
   end

   // r0 reads as zero whatever was written
   assign rd1 = (rs == '0) ? '0 : regs[rs];
   assign rd2 = (rt == '0) ? '0 : regs[rt];

   // decode must stay quiet while the file is cleared
   assert property (@(posedge clk) reset |-> !regWrite)
      else $error("regWrite during reset");

endmodule

// ==== hw/mipsTop.sv ====
`timescale 1ns/10ps
`include "mipsDefs.svh"

module mipsTop
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic [`MIPS_WIDTH-1:0] readData,
   output logic [`MIPS_WIDTH-1:0] adr,
   output logic [`MIPS_WIDTH-1:0] writeData,
   output logic                   memRead,
   output logic                   memWrite,
   output mipsPkg::storeSizeT     storeSize
);

   logic                   irWrite, pcWrite, branchEq, branchNe;
   logic                   iOrD, regWrite, memToReg, zero;
   mipsPkg::pcSrcT         pcSrc;
   mipsPkg::srcASelT       srcASel;
   mipsPkg::srcBSelT       srcBSel;
   mipsPkg::aluFuncT       aluFunc;
   mipsPkg::regDstT        regDst;
   logic [`MIPS_WIDTH-1:0] pc, instr, aluResult, aluOut, rd1, rd2;

   ////////////////////////////////////////////////////////////////////
   // control

   mipsDecode decode (
      .clk(clk), .reset(reset),
      .op(mipsPkg::opcodeT'(instr[31:26])),
      .funct(mipsPkg::functT'(instr[5:0])),
      .irWrite(irWrite), .pcWrite(pcWrite),
      .branchEq(branchEq), .branchNe(branchNe), .pcSrc(pcSrc),
      .iOrD(iOrD), .memRead(memRead), .memWrite(memWrite), .storeSize(storeSize),
      .srcASel(srcASel), .srcBSel(srcBSel), .aluFunc(aluFunc),
      .regWrite(regWrite), .regDst(regDst), .memToReg(memToReg)
   );

   ////////////////////////////////////////////////////////////////////
   // datapath

   mipsFetch fetch (
      .clk(clk), .reset(reset), .readData(readData),
      .irWrite(irWrite), .pcWrite(pcWrite),
      .branchEq(branchEq), .branchNe(branchNe), .pcSrc(pcSrc),
      .aluResult(aluResult), .aluOut(aluOut), .zero(zero),
      .pc(pc), .instr(instr)
   );

   mipsExecute execute (
      .clk(clk), .pc(pc), .instr(instr), .rd1(rd1), .rd2(rd2),
      .srcASel(srcASel), .srcBSel(srcBSel), .aluFunc(aluFunc),
      .aluResult(aluResult), .aluOut(aluOut), .zero(zero),
      .writeData(writeData)
   );

   mipsResult result (
      .clk(clk), .reset(reset), .instr(instr), .readData(readData),
      .aluOut(aluOut), .regWrite(regWrite), .regDst(regDst),
      .memToReg(memToReg), .rd1(rd1), .rd2(rd2)
   );

   // instruction or data address
   assign adr = iOrD ? aluOut : pc;

endmodule

// ==== tb/mipsTb.sv ====
`timescale 1ns/10ps
`include "mipsDefs.svh"

module mipsTb;

   localparam int MemWords  = 128;    // program at 0x000 and data at 0x100
   localparam int MaxStores = 32;

   logic                   clk;
   logic                   reset;
   logic [`MIPS_WIDTH-1:0] readData;
   logic [`MIPS_WIDTH-1:0] adr, writeData;
   logic                   memRead, memWrite;
   mipsPkg::storeSizeT     storeSize;

   logic [31:0]            mem [MemWords];
   logic [31:0]            expAdr [MaxStores];
   mipsPkg::storeSizeT     expSize [MaxStores];
   logic [31:0]            expData [MaxStores];
   int                     nExp, nProg;
   int                     checks, mismatches, timeouts, extras;
   integer                 seed;

   mipsTop DUT (
      .clk(clk), .reset(reset), .readData(readData),
      .adr(adr), .writeData(writeData),
      .memRead(memRead), .memWrite(memWrite), .storeSize(storeSize)
   );

   always #50 clk = ~clk;   // 100 ns period

   // memory answers on the falling edge of a cycle with memRead high
   initial
   begin
      readData = '0;
      forever
      begin
         @(negedge clk);
         readData <= memRead ? mem[adr[8:2]] : '0;
      end
   end

   ////////////////////////////////////////////////////////////////////
   // instruction encoding and tables

   function automatic logic [31:0] rFormat(input int rs, input int rt, input int rd,
                                           input int shamt, input mipsPkg::functT fn);
      return {mipsPkg::opRtype, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], fn};
   endfunction

   function automatic logic [31:0] iFormat(input mipsPkg::opcodeT op, input int rs,
                                           input int rt, input logic [15:0] imm);
      return {op, rs[4:0], rt[4:0], imm};
   endfunction

   function automatic logic [31:0] jFormat(input int wordIdx);
      return {mipsPkg::opJ, wordIdx[25:0]};
   endfunction

   task automatic emit(input logic [31:0] word);
      mem[nProg] = word;
      nProg++;
   endtask

   task automatic addStore(input logic [31:0] a, input mipsPkg::storeSizeT s,
                           input logic [31:0] d);
      expAdr[nExp] = a;
      expSize[nExp] = s;
      expData[nExp] = d;
      nExp++;
   endtask

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         mismatches++;
         $display("FAIL t=%0t %s: got %h expected %h", $time, name, got, exp);
      end
   endtask

   ////////////////////////////////////////////////////////////////////
   // main sequence

   initial
   begin
      logic [15:0] immA, immB, immC, immD;
      logic [31:0] rnd, dataWord, vA, vB, vC, vD, vAdd, vSub, vOr, vSll, mask;
      int          shamt, waitCycles, i;
      bit          seen, timedOut;

      clk = 1'b0;
      reset = 1'b1;
      seed = 32'hed88;
      nExp = 0;
      nProg = 0;
      checks = 0;
      mismatches = 0;
      timeouts = 0;
      extras = 0;

      rnd = $random(seed);
      immA = rnd[15:0];
      rnd = $random(seed);
      immB = rnd[15:0];
      if (immA == immB)
         immB = ~immA;             // keeps r1 and r2 apart for the branches
      rnd = $random(seed);
      immC = rnd[15:0];
      rnd = $random(seed);
      immD = rnd[15:0];
      dataWord = $random(seed);
      shamt = ($random(seed) & 15) | 1;

      // expected results from the instruction rules
      vA = {{16{immA[15]}}, immA};   // addi sign-extends
      vB = {16'h0000, immB};         // ori zero-extends
      vC = vA & {16'h0000, immC};
      vD = {immD, 16'h0000};
      vAdd = vA + vB;
      vSub = vA - vB;
      vOr = vA | vD;
      vSll = vA << shamt;

      for (i = 0; i < MemWords; i++)
         mem[i] = 32'hfc00_0000 | 32'(i);   // unknown opcode tagged by address
      mem[64] = dataWord;                    // 0x100

      emit(iFormat(mipsPkg::opAddi, 0, 1, immA));
      emit(iFormat(mipsPkg::opOri, 0, 2, immB));
      emit(iFormat(mipsPkg::opAndi, 1, 3, immC));
      emit(iFormat(mipsPkg::opLui, 0, 4, immD));
      emit(iFormat(mipsPkg::opSb, 0, 1, 16'h0200));
      addStore(32'h200, mipsPkg::sizeByte, vA);
      emit(iFormat(mipsPkg::opSh, 0, 2, 16'h0202));
      addStore(32'h202, mipsPkg::sizeHalf, vB);
      emit(iFormat(mipsPkg::opSh, 0, 3, 16'h0204));
      addStore(32'h204, mipsPkg::sizeHalf, vC);
      emit(rFormat(0, 4, 5, 16, mipsPkg::fnSrl));     // lui value back down
      emit(iFormat(mipsPkg::opSh, 0, 5, 16'h0206));
      addStore(32'h206, mipsPkg::sizeHalf, vD >> 16);
      emit(rFormat(1, 2, 6, 0, mipsPkg::fnAdd));
      emit(iFormat(mipsPkg::opSh, 0, 6, 16'h0208));
      addStore(32'h208, mipsPkg::sizeHalf, vAdd);
      emit(rFormat(0, 6, 7, 16, mipsPkg::fnSrl));
      emit(iFormat(mipsPkg::opSh, 0, 7, 16'h020a));
      addStore(32'h20a, mipsPkg::sizeHalf, vAdd >> 16);
      emit(rFormat(1, 2, 8, 0, mipsPkg::fnSub));
      emit(iFormat(mipsPkg::opSh, 0, 8, 16'h020c));
      addStore(32'h20c, mipsPkg::sizeHalf, vSub);
      emit(rFormat(1, 4, 9, 0, mipsPkg::fnOr));
      emit(rFormat(0, 9, 10, 16, mipsPkg::fnSrl));
      emit(iFormat(mipsPkg::opSh, 0, 10, 16'h020e));
      addStore(32'h20e, mipsPkg::sizeHalf, vOr >> 16);
      emit(rFormat(0, 1, 11, shamt, mipsPkg::fnSll));
      emit(iFormat(mipsPkg::opSh, 0, 11, 16'h0210));
      addStore(32'h210, mipsPkg::sizeHalf, vSll);
      emit(iFormat(mipsPkg::opLw, 0, 12, 16'h0100));
      emit(iFormat(mipsPkg::opSh, 0, 12, 16'h0212));
      addStore(32'h212, mipsPkg::sizeHalf, dataWord);

      // branch markers at 0x2f0 and up must never show
      emit(iFormat(mipsPkg::opBeq, 1, 1, 16'h0001));  // taken
      emit(iFormat(mipsPkg::opSb, 0, 1, 16'h02f0));
      emit(iFormat(mipsPkg::opSb, 0, 2, 16'h0220));
      addStore(32'h220, mipsPkg::sizeByte, vB);
      emit(iFormat(mipsPkg::opBeq, 1, 2, 16'h0001));  // not taken
      emit(iFormat(mipsPkg::opSb, 0, 3, 16'h0221));
      addStore(32'h221, mipsPkg::sizeByte, vC);
      emit(iFormat(mipsPkg::opBne, 1, 2, 16'h0001));  // taken
      emit(iFormat(mipsPkg::opSb, 0, 1, 16'h02f1));
      emit(iFormat(mipsPkg::opSb, 0, 5, 16'h0222));
      addStore(32'h222, mipsPkg::sizeByte, vD >> 16);
      emit(iFormat(mipsPkg::opBne, 1, 1, 16'h0001));  // not taken
      emit(iFormat(mipsPkg::opSb, 0, 6, 16'h0223));
      addStore(32'h223, mipsPkg::sizeByte, vAdd);
      emit(jFormat(nProg + 2));
      emit(iFormat(mipsPkg::opSb, 0, 1, 16'h02f2));
      emit(iFormat(mipsPkg::opSb, 0, 7, 16'h0224));
      addStore(32'h224, mipsPkg::sizeByte, vAdd >> 16);
      emit(jFormat(nProg));                          // self loop

      repeat (3) @(negedge clk);
      // still in Fetch with pc at the reset value
      checkValue("adr", adr, 32'h0);
      checkValue("memRead", 32'(memRead), 32'h1);
      checkValue("memWrite", 32'(memWrite), 32'h0);
      reset <= 1'b0;

      timedOut = 1'b0;
      for (i = 0; i < nExp && !timedOut; i++)
      begin
         seen = 1'b0;
         waitCycles = 0;
         while (!seen && waitCycles < 60)
         begin
            @(negedge clk);
            seen = memWrite;
            waitCycles++;
         end
         if (!seen)
         begin
            timeouts++;
            timedOut = 1'b1;
            $display("timeout: store %0d to address %h never came", i, expAdr[i]);
         end
         else
         begin
            mask = (expSize[i] == mipsPkg::sizeByte) ? 32'h0000_00ff : 32'h0000_ffff;
            checkValue("adr", adr, expAdr[i]);
            checkValue("storeSize", 32'(storeSize), 32'(expSize[i]));
            checkValue("writeData", writeData & mask, expData[i] & mask);
         end
      end

      // bus stays quiet once the self loop is reached
      if (!timedOut)
      begin
         for (i = 0; i < 40; i++)
         begin
            @(negedge clk);
            if (memWrite)
            begin
               extras++;
               $display("unexpected store to address %h after the last expected one", adr);
            end
         end
      end

      $display("%0d checks, %0d mismatches, %0d timeouts, %0d extra stores",
               checks, mismatches, timeouts, extras);
      if (mismatches + timeouts + extras == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

// ==== flist.f ====
+incdir+hw
hw/mipsPkg.sv
hw/mipsDecode.sv
hw/mipsFetch.sv
hw/mipsExecute.sv
hw/mipsResult.sv
hw/mipsTop.sv
tb/mipsTb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module mipsTb -f flist.f -o mipsSim || exit 1
out=$(./obj_dir/mipsSim)
echo "$out"
echo "$out" | grep -qx "all tests passed" && exit 0 || exit 1
